// ==== rtl/bf_pixel_pkg.sv ====
`default_nettype none

package bf_pixel_pkg;

  // ------------------------------------------------------------
  // image geometry
  // ------------------------------------------------------------
  localparam int PIX_W      = 8;
  localparam int IMG_WIDTH  = 6;
  localparam int IMG_HEIGHT = 4;
  localparam int COL_W      = $clog2(IMG_WIDTH);
  localparam int ROW_W      = $clog2(IMG_HEIGHT);

  // 3x3 window, row-major, tap 0 top left
  localparam int N_TAPS     = 9;
  localparam int CENTER_TAP = 4;

  typedef logic [PIX_W-1:0] pixel_t;

  typedef struct packed {
    pixel_t [N_TAPS-1:0] tap;
    // row < 2 or column < 2 at the newest pixel
    logic                edge_flag;
  } window_t;

  typedef struct packed {
    logic vsync;
    logic hsync;
    logic valid;
  } sync_t;

endpackage

`default_nettype wire

// ==== rtl/bf_weight_pkg.sv ====
`default_nettype none

package bf_weight_pkg;
  import bf_pixel_pkg::*;

  // ------------------------------------------------------------
  // weight widths
  // ------------------------------------------------------------
  localparam int SIM_W      = 10;
  localparam int GAUSS_W    = 7;
  localparam int WEIGHT_W   = SIM_W + GAUSS_W;
  localparam int WSUM_W     = 21;
  localparam int NORM_SHIFT = 10;
  // lone centre weight gives exactly 1 << NORM_SHIFT
  localparam int NORM_W     = NORM_SHIFT + 1;
  localparam int ACC_W      = 23;

  typedef logic [SIM_W-1:0]    sim_t;
  typedef logic [WEIGHT_W-1:0] weight_t;
  typedef logic [WSUM_W-1:0]   wsum_t;
  typedef logic [NORM_W-1:0]   norm_t;
  typedef logic [ACC_W-1:0]    acc_t;

  // spatial gaussian, corners / sides / centre
  localparam logic [GAUSS_W-1:0] GAUSS_TAB [N_TAPS] = '{
    7'd109, 7'd115, 7'd109,
    7'd115, 7'd122, 7'd115,
    7'd109, 7'd115, 7'd109
  };

  // range kernel
  localparam int SIM_MAX   = (1 << SIM_W) - 1;
  localparam int SIM_RANGE = 64;
  localparam int SIM_SLOPE = 16;

  // ------------------------------------------------------------
  // stage latencies
  // ------------------------------------------------------------
  localparam int LANE_LAT = 2;
  localparam int NORM_LAT = 3;
  localparam int CONV_LAT = 3;
  localparam int DATA_LAT = LANE_LAT + NORM_LAT;
  localparam int SYNC_LAT = DATA_LAT + CONV_LAT;

  function automatic sim_t similarity(input pixel_t diff);
    sim_t sim;
    if (int'(diff) < SIM_RANGE) begin
      sim = sim_t'(SIM_MAX - SIM_SLOPE * int'(diff));
    end else begin
      sim = '0;
    end
    return sim;
  endfunction

endpackage

`default_nettype wire

// ==== rtl/bf_window_gen.sv ====
`default_nettype none

module bf_window_gen
  import bf_pixel_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    vsync,
  input  logic    hsync,
  input  logic    valid,
  input  pixel_t  data,
  output window_t win,
  output sync_t   win_sync
);

  logic [COL_W-1:0] col_cnt;
  logic [ROW_W-1:0] row_cnt;

  // line1 holds row r-1, line2 holds row r-2
  pixel_t line1 [IMG_WIDTH];
  pixel_t line2 [IMG_WIDTH];

  pixel_t top_px;
  pixel_t mid_px;

  assign top_px = line2[col_cnt];
  assign mid_px = line1[col_cnt];

  // ------------------------------------------------------------
  // frame position
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (vsync) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (valid) begin
      if (col_cnt == COL_W'(IMG_WIDTH - 1)) begin
        col_cnt <= '0;
        if (row_cnt == ROW_W'(IMG_HEIGHT - 1)) begin
          row_cnt <= '0;
        end else begin
          row_cnt <= row_cnt + 1'b1;
        end
      end else begin
        col_cnt <= col_cnt + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // line buffers and window shift
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (valid) begin
      line1[col_cnt] <= data;
      line2[col_cnt] <= mid_px;
    end
  end

  always_ff @(posedge clk) begin
    if (valid) begin
      // oldest column moves left
      win.tap[0] <= win.tap[1];
      win.tap[1] <= win.tap[2];
      win.tap[2] <= top_px;
      win.tap[3] <= win.tap[4];
      win.tap[4] <= win.tap[5];
      win.tap[5] <= mid_px;
      win.tap[6] <= win.tap[7];
      win.tap[7] <= win.tap[8];
      win.tap[8] <= data;
      win.edge_flag <= (row_cnt < ROW_W'(2)) || (col_cnt < COL_W'(2));
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      win_sync <= '0;
    end else begin
      win_sync.vsync <= vsync;
      win_sync.hsync <= hsync;
      win_sync.valid <= valid;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/bf_weight_lane.sv ====
`default_nettype none

module bf_weight_lane
  import bf_pixel_pkg::*;
  import bf_weight_pkg::*;
(
  input  logic               clk,
  input  pixel_t             tap,
  input  pixel_t             center,
  input  logic [GAUSS_W-1:0] gauss,
  output weight_t            weight
);

  pixel_t diff;

  // stage 1, absolute difference to the centre
  always_ff @(posedge clk) begin
    if (tap > center) begin
      diff <= tap - center;
    end else begin
      diff <= center - tap;
    end
  end

  // stage 2, range weight times spatial weight
  always_ff @(posedge clk) begin
    weight <= weight_t'(similarity(diff)) * weight_t'(gauss);
  end

endmodule

`default_nettype wire

// ==== rtl/bf_normalizer.sv ====
`default_nettype none

module bf_normalizer
  import bf_pixel_pkg::*;
  import bf_weight_pkg::*;
(
  input  logic    clk,
  input  weight_t weights [N_TAPS],
  output norm_t   norm    [N_TAPS]
);

  wsum_t   row_sum [3];
  wsum_t   total;
  weight_t weights_d1 [N_TAPS];
  weight_t weights_d2 [N_TAPS];

  // ------------------------------------------------------------
  // sum tree
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    for (int r = 0; r < 3; r++) begin
      row_sum[r] <= wsum_t'(weights[3*r])
                  + wsum_t'(weights[3*r+1])
                  + wsum_t'(weights[3*r+2]);
    end
  end

  always_ff @(posedge clk) begin
    total <= row_sum[0] + row_sum[1] + row_sum[2];
  end

  // weights wait for the total
  always_ff @(posedge clk) begin
    for (int i = 0; i < N_TAPS; i++) begin
      weights_d1[i] <= weights[i];
      weights_d2[i] <= weights_d1[i];
    end
  end

  // ------------------------------------------------------------
  // divide to 1024 scale
  // ------------------------------------------------------------
  // total never zero, the centre lane always has full similarity
  always_ff @(posedge clk) begin
    for (int i = 0; i < N_TAPS; i++) begin
      norm[i] <= norm_t'({weights_d2[i], {NORM_SHIFT{1'b0}}} / total);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/bf_pipe_delay.sv ====
`default_nettype none

module bf_pipe_delay #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1
) (
  input  logic     clk,
  input  logic     rst_n,
  input  payload_t din,
  output payload_t dout
);

  payload_t stage [DEPTH];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign dout = stage[DEPTH-1];

endmodule

`default_nettype wire

// ==== rtl/bf_convolver.sv ====
`default_nettype none

module bf_convolver
  import bf_pixel_pkg::*;
  import bf_weight_pkg::*;
(
  input  logic    clk,
  input  window_t win,
  input  norm_t   norm [N_TAPS],
  output pixel_t  result
);

  acc_t   prod    [N_TAPS];
  acc_t   row_sum [3];
  acc_t   total;
  logic [ACC_W-NORM_SHIFT:0] rounded;
  pixel_t filtered;

  logic   edge_d1;
  logic   edge_d2;
  pixel_t newest_d1;
  pixel_t newest_d2;

  // stage 1, tap times weight
  always_ff @(posedge clk) begin
    for (int i = 0; i < N_TAPS; i++) begin
      prod[i] <= acc_t'(win.tap[i]) * acc_t'(norm[i]);
    end
    edge_d1   <= win.edge_flag;
    newest_d1 <= win.tap[N_TAPS-1];
  end

  // stage 2, row sums
  always_ff @(posedge clk) begin
    for (int r = 0; r < 3; r++) begin
      row_sum[r] <= prod[3*r] + prod[3*r+1] + prod[3*r+2];
    end
    edge_d2   <= edge_d1;
    newest_d2 <= newest_d1;
  end

  // ------------------------------------------------------------
  // stage 3, round, saturate, edge bypass
  // ------------------------------------------------------------
  assign total    = row_sum[0] + row_sum[1] + row_sum[2];
  assign rounded  = total[ACC_W-1:NORM_SHIFT] + total[NORM_SHIFT-1];
  assign filtered = (rounded[ACC_W-NORM_SHIFT:PIX_W] != '0) ? '1 :
                    rounded[PIX_W-1:0];

  always_ff @(posedge clk) begin
    if (edge_d2) begin
      result <= newest_d2;
    end else begin
      result <= filtered;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/bilateral_filter.sv ====
`default_nettype none

module bilateral_filter
  import bf_pixel_pkg::*;
  import bf_weight_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   vsync,
  input  logic   hsync,
  input  logic   valid,
  input  pixel_t data,
  output logic   post_vsync,
  output logic   post_hsync,
  output logic   post_valid,
  output pixel_t post_data
);

  window_t win;
  window_t win_d;
  sync_t   win_sync;
  sync_t   post_sync;
  weight_t weights [N_TAPS];
  norm_t   norm    [N_TAPS];

  bf_window_gen u_window_gen (
    .clk      (clk),
    .rst_n    (rst_n),
    .vsync    (vsync),
    .hsync    (hsync),
    .valid    (valid),
    .data     (data),
    .win      (win),
    .win_sync (win_sync)
  );

  // ------------------------------------------------------------
  // one range/spatial weight per tap
  // ------------------------------------------------------------
  for (genvar g = 0; g < N_TAPS; g++) begin : g_lane
    bf_weight_lane u_lane (
      .clk    (clk),
      .tap    (win.tap[g]),
      .center (win.tap[CENTER_TAP]),
      .gauss  (GAUSS_TAB[g]),
      .weight (weights[g])
    );
  end

  bf_normalizer u_normalizer (
    .clk     (clk),
    .weights (weights),
    .norm    (norm)
  );

  // window waits for the weights
  bf_pipe_delay #(
    .payload_t (window_t),
    .DEPTH     (DATA_LAT)
  ) u_win_delay (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (win),
    .dout  (win_d)
  );

  bf_pipe_delay #(
    .payload_t (sync_t),
    .DEPTH     (SYNC_LAT)
  ) u_sync_delay (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (win_sync),
    .dout  (post_sync)
  );

  bf_convolver u_convolver (
    .clk    (clk),
    .win    (win_d),
    .norm   (norm),
    .result (post_data)
  );

  assign post_vsync = post_sync.vsync;
  assign post_hsync = post_sync.hsync;
  assign post_valid = post_sync.valid;

endmodule

`default_nettype wire

// ==== verif/tb_bilateral_filter.sv ====
`default_nettype none

module tb_bilateral_filter
  import bf_pixel_pkg::*;
();

  localparam int RESET_CYCLES = 5;
  localparam int IDLE_CYCLES  = 8;
  localparam int LATENCY      = 9;
  localparam int MARGIN       = 20;
  localparam int N_LINES      = 44;
  localparam int N_FIELDS     = 5;
  localparam int CYCLE_LIMIT  = RESET_CYCLES + IDLE_CYCLES + N_LINES + LATENCY + MARGIN;

  // field order within one stim line
  localparam int F_VSYNC  = 0;
  localparam int F_HSYNC  = 1;
  localparam int F_VALID  = 2;
  localparam int F_PIXEL  = 3;
  localparam int F_EXPECT = 4;

  logic   clk;
  logic   rst_n;
  logic   vsync;
  logic   hsync;
  logic   valid;
  pixel_t data;
  logic   post_vsync;
  logic   post_hsync;
  logic   post_valid;
  pixel_t post_data;

  logic [7:0] stim_mem [N_LINES*N_FIELDS];
  logic [2:0] sync_q [$];
  pixel_t     expect_q [$];

  string test_names [3] = '{"idle_after_reset", "strobe_delay", "pixel_data"};
  int    test_checks [3] = '{0, 0, 0};
  int    test_errors [3] = '{0, 0, 0};
  int    cycle_count = 0;

  bilateral_filter UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .vsync      (vsync),
    .hsync      (hsync),
    .valid      (valid),
    .data       (data),
    .post_vsync (post_vsync),
    .post_hsync (post_hsync),
    .post_valid (post_valid),
    .post_data  (post_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the run did not reach its end", cycle_count);
      $display("Something failed");
      $finish;
    end
  end

  task automatic check_value(input int test_id, input string name,
                             input logic [31:0] actual, input logic [31:0] expected);
    test_checks[test_id]++;
    if (actual !== expected) begin
      test_errors[test_id]++;
      $display("Error at time %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual,
               expected);
    end
  endtask

  // every field of every line must hold a known value
  function automatic bit stim_loaded();
    for (int i = 0; i < N_LINES*N_FIELDS; i++) begin
      if ($isunknown(stim_mem[i])) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic drive_inputs(input logic [2:0] strobes, input pixel_t px);
    vsync = strobes[2];
    hsync = strobes[1];
    valid = strobes[0];
    data  = px;
  endtask

  task automatic apply_line(input int idx);
    int         base;
    logic [2:0] strobes;
    base    = idx * N_FIELDS;
    strobes = {stim_mem[base+F_VSYNC][0], stim_mem[base+F_HSYNC][0],
               stim_mem[base+F_VALID][0]};
    drive_inputs(strobes, stim_mem[base+F_PIXEL]);
    sync_q.push_back(strobes);
    if (strobes[0]) begin
      expect_q.push_back(stim_mem[base+F_EXPECT]);
    end
  endtask

  // ------------------------------------------------------------
  // strobes come out 9 cycles behind the inputs
  // ------------------------------------------------------------
  task automatic compare_outputs();
    logic [2:0] exp_sync;
    pixel_t     exp_pix;
    exp_sync = sync_q.pop_front();
    check_value(1, "post_vsync", post_vsync, exp_sync[2]);
    check_value(1, "post_hsync", post_hsync, exp_sync[1]);
    check_value(1, "post_valid", post_valid, exp_sync[0]);
    if (post_valid === 1'b1) begin
      if (expect_q.size() == 0) begin
        test_errors[2]++;
        $display("Output pixel at time %0t arrived with no input pixel pending", $time);
      end else begin
        exp_pix = expect_q.pop_front();
        check_value(2, "post_data", post_data, exp_pix);
      end
    end
  endtask

  task automatic report_test(input int test_id);
    $display("test %s: %0d checks, %0d errors", test_names[test_id],
             test_checks[test_id], test_errors[test_id]);
  endtask

  initial begin
    int total_checks;
    int total_errors;
    rst_n = 1'b0;
    drive_inputs('0, '0);
    $readmemh("verif/bf_stim.txt", stim_mem);
    if (!stim_loaded()) begin
      test_errors[1]++;
      $display("The stimulus file could not be read completely");
    end
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    // strobes must stay low before any input
    repeat (IDLE_CYCLES) begin
      @(negedge clk);
      check_value(0, "post_vsync", post_vsync, 0);
      check_value(0, "post_hsync", post_hsync, 0);
      check_value(0, "post_valid", post_valid, 0);
    end
    report_test(0);

    repeat (LATENCY) sync_q.push_back('0);
    for (int i = 0; i < N_LINES; i++) begin
      @(negedge clk);
      compare_outputs();
      apply_line(i);
    end
    // drain the pipeline
    repeat (LATENCY) begin
      @(negedge clk);
      compare_outputs();
      drive_inputs('0, '0);
      sync_q.push_back('0);
    end
    if (expect_q.size() != 0) begin
      test_errors[2]++;
      $display("%0d input pixels never reached the output", expect_q.size());
    end
    report_test(1);
    report_test(2);

    total_checks = test_checks[0] + test_checks[1] + test_checks[2];
    total_errors = test_errors[0] + test_errors[1] + test_errors[2];
    $display("3 tests, %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/bf_stim.txt ====
// vsync hsync valid pixel expected_out, all hex, one line per clock cycle
// frame 1 flat 0x50, frame 2 step 0x20/0xC8 over 0x30/0xD0
1 0 0 00 00
0 1 1 50 50
0 1 1 50 50
0 1 1 50 50
0 1 1 50 50
0 1 1 50 50
0 1 1 50 50
0 0 0 00 00
0 1 1 50 50
0 1 1 50 50
0 1 1 50 50
0 1 1 50 50
0 1 1 50 50
0 1 1 50 50
0 0 0 00 00
0 1 1 50 50
0 1 1 50 50
0 1 1 50 50
0 1 1 50 50
0 1 1 50 50
0 1 1 50 50
0 0 0 00 00
1 0 0 00 00
0 1 1 20 20
0 1 1 20 20
0 1 1 20 20
0 1 1 C8 C8
0 1 1 C8 C8
0 1 1 C8 C8
0 0 0 00 00
0 1 1 20 20
0 1 1 20 20
0 1 1 20 20
0 1 1 C8 C8
0 1 1 C8 C8
0 1 1 C8 C8
0 0 0 00 00
0 1 1 30 30
0 1 1 30 30
0 1 1 30 24
0 1 1 D0 24
0 1 1 D0 CA
0 1 1 D0 CA
0 0 0 00 00

// ==== filelist.f ====
rtl/bf_pixel_pkg.sv
rtl/bf_weight_pkg.sv
rtl/bf_window_gen.sv
rtl/bf_weight_lane.sv
rtl/bf_normalizer.sv
rtl/bf_pipe_delay.sv
rtl/bf_convolver.sv
rtl/bilateral_filter.sv
verif/tb_bilateral_filter.sv

// ==== Bender.yml ====
package:
  name: bilateral_filter

sources:
  - files:
      - rtl/bf_pixel_pkg.sv
      - rtl/bf_weight_pkg.sv
      - rtl/bf_window_gen.sv
      - rtl/bf_weight_lane.sv
      - rtl/bf_normalizer.sv
      - rtl/bf_pipe_delay.sv
      - rtl/bf_convolver.sv
      - rtl/bilateral_filter.sv
  - target: test
    files:
      - verif/tb_bilateral_filter.sv
